/* list.f */
+incdir+logic
logic/fp_pkg.sv
logic/cmp_pkg.sv
logic/handshake_join.sv
logic/fp_classify.sv
logic/fp_compare_pipe.sv
logic/cmp_config_regs.sv
logic/fp_cmp_top.sv
verification/tb_clock_gen.sv
verification/fp_cmp_props.sv
verification/fp_cmp_tb.sv

/* logic/cmp_config_regs.sv */
`include "fp_cmp_defs.svh"

module cmp_config_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfg_write,
  input  logic [`PRED_WIDTH-1:0] cfg_predicate,
  output cmp_pkg::cmp_pred_e     predicate,
  output logic                   predicate_error
);

  logic code_ok;
  logic write_good;
  logic write_bad;

  assign code_ok    = cmp_pkg::pred_defined(cfg_predicate);
  assign write_good = cfg_write && code_ok;
  assign write_bad  = cfg_write && !code_ok;

  // Active predicate, only replaced by a defined code
  always_ff @(posedge clk) begin
    if (reset) begin
      predicate <= cmp_pkg::PRED_RESET;
    end else if (write_good) begin
      predicate <= cmp_pkg::cmp_pred_e'(cfg_predicate);
    end
  end

  // Sticky until the next defined write
  always_ff @(posedge clk) begin
    if (reset) begin
      predicate_error <= 1'b0;
    end else if (write_bad) begin
      predicate_error <= 1'b1;
    end else if (write_good) begin
      predicate_error <= 1'b0;
    end
  end

endmodule

/* logic/cmp_pkg.sv */
`include "fp_cmp_defs.svh"

package cmp_pkg;

  // Ordered forms fail on NaN, unordered forms pass on NaN
  typedef enum logic [`PRED_WIDTH-1:0] {
    OEQ = 4'd0,
    OGT = 4'd1,
    OGE = 4'd2,
    OLT = 4'd3,
    OLE = 4'd4,
    ONE = 4'd5,
    ORD = 4'd6,
    UEQ = 4'd7,
    UGT = 4'd8,
    UGE = 4'd9,
    ULT = 4'd10,
    ULE = 4'd11,
    UNE = 4'd12,
    UNO = 4'd13
  } cmp_pred_e;

  localparam cmp_pred_e PRED_RESET = OEQ;

  // Codes above UNO are undefined
  function automatic logic pred_defined(input logic [`PRED_WIDTH-1:0] code);
    return code <= UNO;
  endfunction

endpackage

/* logic/fp_classify.sv */
`include "fp_cmp_defs.svh"

module fp_classify (
  input  logic [`FP_WIDTH-1:0] value,
  output fp_pkg::fp_class_e    fp_class,
  output logic [`FP_WIDTH-1:0] order_key
);

  fp_pkg::fp32_t fields;
  logic          exp_zero;
  logic          exp_special;
  logic          mant_zero;

  assign fields = value;

  assign exp_zero    = fields.exponent == '0;
  assign exp_special = fields.exponent == fp_pkg::EXP_SPECIAL;
  assign mant_zero   = fields.mantissa == '0;

  // Denormals fall under finite
  always_comb begin
    if (exp_special && mant_zero) begin
      fp_class = fp_pkg::INF;
    end else if (exp_special) begin
      fp_class = fp_pkg::NAN;
    end else if (exp_zero && mant_zero) begin
      fp_class = fp_pkg::ZERO;
    end else begin
      fp_class = fp_pkg::FINITE;
    end
  end

  // Unsigned compare of keys gives numeric order
  always_comb begin
    if (fp_class == fp_pkg::ZERO) begin
      order_key = fp_pkg::ZERO_KEY;
    end else if (fields.sign) begin
      // Larger magnitude negatives sort lower
      order_key = ~value;
    end else begin
      order_key = {1'b1, value[`FP_WIDTH-2:0]};
    end
  end

endmodule

/* logic/fp_cmp_defs.svh */
`ifndef FP_CMP_DEFS_SVH
`define FP_CMP_DEFS_SVH

// IEEE single precision operand
`define FP_WIDTH 32

// Predicate code, 14 defined of 16
`define PRED_WIDTH 4

// Registered stages between pair acceptance and result
`define CMP_STAGES 2

`endif

/* logic/fp_cmp_top.sv */
`include "fp_cmp_defs.svh"

module fp_cmp_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`FP_WIDTH-1:0]   lhs,
  input  logic                   lhs_valid,
  input  logic [`FP_WIDTH-1:0]   rhs,
  input  logic                   rhs_valid,
  input  logic                   result_ready,
  input  logic                   cfg_write,
  input  logic [`PRED_WIDTH-1:0] cfg_predicate,
  output logic                   lhs_ready,
  output logic                   rhs_ready,
  output logic                   result,
  output logic                   result_valid,
  output logic                   predicate_error
);

  logic                 pipe_ready;
  logic                 pair_accept;
  fp_pkg::fp_class_e    lhs_class;
  fp_pkg::fp_class_e    rhs_class;
  logic [`FP_WIDTH-1:0] lhs_key;
  logic [`FP_WIDTH-1:0] rhs_key;
  cmp_pkg::cmp_pred_e   predicate;

  handshake_join u_join (
    .lhs_valid   (lhs_valid),
    .rhs_valid   (rhs_valid),
    .pipe_ready  (pipe_ready),
    .lhs_ready   (lhs_ready),
    .rhs_ready   (rhs_ready),
    .pair_accept (pair_accept)
  );

  fp_classify u_lhs_class (
    .value     (lhs),
    .fp_class  (lhs_class),
    .order_key (lhs_key)
  );

  fp_classify u_rhs_class (
    .value     (rhs),
    .fp_class  (rhs_class),
    .order_key (rhs_key)
  );

  fp_compare_pipe u_pipe (
    .clk          (clk),
    .reset        (reset),
    .accept       (pair_accept),
    .lhs_class    (lhs_class),
    .lhs_key      (lhs_key),
    .rhs_class    (rhs_class),
    .rhs_key      (rhs_key),
    .predicate    (predicate),
    .result_ready (result_ready),
    .pipe_ready   (pipe_ready),
    .result       (result),
    .result_valid (result_valid)
  );

  cmp_config_regs u_config (
    .clk             (clk),
    .reset           (reset),
    .cfg_write       (cfg_write),
    .cfg_predicate   (cfg_predicate),
    .predicate       (predicate),
    .predicate_error (predicate_error)
  );

endmodule

/* logic/fp_compare_pipe.sv */
`include "fp_cmp_defs.svh"

module fp_compare_pipe (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  accept,
  input  fp_pkg::fp_class_e     lhs_class,
  input  logic [`FP_WIDTH-1:0]  lhs_key,
  input  fp_pkg::fp_class_e     rhs_class,
  input  logic [`FP_WIDTH-1:0]  rhs_key,
  input  cmp_pkg::cmp_pred_e    predicate,
  input  logic                  result_ready,
  output logic                  pipe_ready,
  output logic                  result,
  output logic                  result_valid
);

  logic [`CMP_STAGES-1:0] stage_valid;
  logic [`CMP_STAGES-1:0] stage_advance;

  fp_pkg::fp_class_e      s1_lhs_class;
  fp_pkg::fp_class_e      s1_rhs_class;
  logic [`FP_WIDTH-1:0]   s1_lhs_key;
  logic [`FP_WIDTH-1:0]   s1_rhs_key;
  cmp_pkg::cmp_pred_e     s1_pred;

  logic s1_unordered;
  logic s1_equal;
  logic s1_less;
  logic s1_relation;
  logic s1_unordered_form;
  logic s1_result;
  logic s2_result;

  // A stage moves when empty or when the next one moves
  assign stage_advance[1] = !stage_valid[1] || result_ready;
  assign stage_advance[0] = !stage_valid[0] || stage_advance[1];
  assign pipe_ready = stage_advance[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      if (stage_advance[0]) begin
        stage_valid[0] <= accept;
      end
      if (stage_advance[1]) begin
        stage_valid[1] <= stage_valid[0];
      end
    end
  end

  // Predicate travels with its pair
  always_ff @(posedge clk) begin
    if (stage_advance[0] && accept) begin
      s1_lhs_class <= lhs_class;
      s1_rhs_class <= rhs_class;
      s1_lhs_key   <= lhs_key;
      s1_rhs_key   <= rhs_key;
      s1_pred      <= predicate;
    end
  end

  assign s1_unordered = (s1_lhs_class == fp_pkg::NAN) || (s1_rhs_class == fp_pkg::NAN);
  assign s1_equal     = s1_lhs_key == s1_rhs_key;
  assign s1_less      = s1_lhs_key < s1_rhs_key;

  // Base relation per predicate, then ordered or unordered wrapping
  always_comb begin
    s1_relation       = 1'b0;
    s1_unordered_form = 1'b0;
    case (s1_pred)
      cmp_pkg::OEQ: s1_relation = s1_equal;
      cmp_pkg::OGT: s1_relation = !s1_equal && !s1_less;
      cmp_pkg::OGE: s1_relation = !s1_less;
      cmp_pkg::OLT: s1_relation = s1_less;
      cmp_pkg::OLE: s1_relation = s1_less || s1_equal;
      cmp_pkg::ONE: s1_relation = !s1_equal;
      cmp_pkg::ORD: s1_relation = 1'b1;
      cmp_pkg::UEQ: {s1_unordered_form, s1_relation} = {1'b1, s1_equal};
      cmp_pkg::UGT: {s1_unordered_form, s1_relation} = {1'b1, !s1_equal && !s1_less};
      cmp_pkg::UGE: {s1_unordered_form, s1_relation} = {1'b1, !s1_less};
      cmp_pkg::ULT: {s1_unordered_form, s1_relation} = {1'b1, s1_less};
      cmp_pkg::ULE: {s1_unordered_form, s1_relation} = {1'b1, s1_less || s1_equal};
      cmp_pkg::UNE: {s1_unordered_form, s1_relation} = {1'b1, !s1_equal};
      cmp_pkg::UNO: s1_unordered_form = 1'b1;
      default: s1_relation = 1'b0;
    endcase
  end

  assign s1_result = s1_unordered_form ? (s1_unordered || s1_relation)
                                       : (!s1_unordered && s1_relation);

  always_ff @(posedge clk) begin
    if (stage_advance[1] && stage_valid[0]) begin
      s2_result <= s1_result;
    end
  end

  assign result       = s2_result;
  assign result_valid = stage_valid[1];

endmodule

/* logic/fp_pkg.sv */
`include "fp_cmp_defs.svh"

package fp_pkg;

  // Operand class after unpacking
  typedef enum logic [1:0] {
    ZERO   = 2'd0,
    FINITE = 2'd1,
    INF    = 2'd2,
    NAN    = 2'd3
  } fp_class_e;

  // Single precision field layout
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  // Exponent of infinity and NaN
  localparam logic [7:0] EXP_SPECIAL = 8'hff;

  // Shared ordering key of +0 and -0
  localparam logic [`FP_WIDTH-1:0] ZERO_KEY = {1'b1, {(`FP_WIDTH-1){1'b0}}};

endpackage

/* logic/handshake_join.sv */
module handshake_join (
  input  logic lhs_valid,
  input  logic rhs_valid,
  input  logic pipe_ready,
  output logic lhs_ready,
  output logic rhs_ready,
  output logic pair_accept
);

  logic both_valid;

  // A pair exists only when both operands are offered
  assign both_valid = lhs_valid && rhs_valid;

  assign pair_accept = both_valid && pipe_ready;

  // Both sides consumed on the same edge, never one alone
  assign lhs_ready = pair_accept;
  assign rhs_ready = pair_accept;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module fp_cmp_tb -f list.f -o fp_cmp_sim

# Let assertion errors accumulate so the testbench can report them
./obj_dir/fp_cmp_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* verification/fp_cmp_props.sv */
module fp_cmp_props (
  input logic clk,
  input logic reset,
  input logic lhs_valid,
  input logic rhs_valid,
  input logic lhs_ready,
  input logic rhs_ready,
  input logic result,
  input logic result_valid,
  input logic result_ready,
  input logic predicate_error
);

  // Read by the testbench at the end of the run
  int failures = 0;

  // Both readies move together and only when both operands are offered
  readies_match: assert property (@(posedge clk)
    lhs_ready == rhs_ready && (!lhs_ready || (lhs_valid && rhs_valid)))
    else begin
      $error("operand readies differ or rose without both operands valid");
      failures++;
    end

  // A stalled result keeps its value until taken
  result_held: assert property (@(posedge clk) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
      $error("result changed or dropped before it was accepted");
      failures++;
    end

  reset_quiet: assert property (@(posedge clk)
    reset && $past(reset) |-> !result_valid && !predicate_error)
    else begin
      $error("result_valid or predicate_error high during reset");
      failures++;
    end

endmodule

/* verification/fp_cmp_tb.sv */
`include "fp_cmp_defs.svh"

module fp_cmp_tb;

  localparam int WAIT_LIMIT   = 200;
  localparam int READY_HIGH   = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_RANDOM = 2;

  localparam logic [31:0] FP_ONE   = 32'h3f80_0000;
  localparam logic [31:0] FP_TWO   = 32'h4000_0000;
  localparam logic [31:0] FP_M_ONE = 32'hbf80_0000;
  localparam logic [31:0] FP_M_TWO = 32'hc000_0000;
  localparam logic [31:0] FP_PINF  = 32'h7f80_0000;
  localparam logic [31:0] FP_MINF  = 32'hff80_0000;
  localparam logic [31:0] FP_QNAN  = 32'h7fc0_0000;

  // Each entry is {lhs, rhs}
  localparam int NUM_DIRECTED = 11;
  localparam logic [63:0] DIRECTED [NUM_DIRECTED] = '{
    {FP_ONE, FP_ONE},
    {FP_ONE, FP_TWO},
    {FP_TWO, FP_ONE},
    {FP_M_ONE, FP_ONE},
    {FP_M_TWO, FP_M_ONE},
    {32'h0000_0000, 32'h8000_0000},
    {FP_PINF, FP_ONE},
    {FP_MINF, FP_PINF},
    {FP_QNAN, FP_ONE},
    {FP_ONE, FP_QNAN},
    {32'h0000_0001, 32'h0000_0000}
  };

  logic                   clk;
  logic                   reset;
  logic [`FP_WIDTH-1:0]   lhs;
  logic                   lhs_valid;
  logic [`FP_WIDTH-1:0]   rhs;
  logic                   rhs_valid;
  logic                   result_ready;
  logic                   cfg_write;
  logic [`PRED_WIDTH-1:0] cfg_predicate;
  logic                   lhs_ready;
  logic                   rhs_ready;
  logic                   result;
  logic                   result_valid;
  logic                   predicate_error;

  // Driver state applied at each falling edge
  logic                   have_pair;
  logic [`FP_WIDTH-1:0]   pair_lhs;
  logic [`FP_WIDTH-1:0]   pair_rhs;
  logic                   cfg_pending;
  logic [`PRED_WIDTH-1:0] cfg_code;
  int                     ready_mode;
  bit                     check_latency;

  // Expected state of the configuration block
  logic [`PRED_WIDTH-1:0] model_pred;
  logic                   model_error;

  bit    exp_q[$];
  int    win_q[$];
  int    window;
  int    checks;
  int    errors;
  int    test_start_errors;
  string test_name;

  tb_clock_gen u_clock (
    .clk (clk)
  );

  fp_cmp_top UUT (
    .clk             (clk),
    .reset           (reset),
    .lhs             (lhs),
    .lhs_valid       (lhs_valid),
    .rhs             (rhs),
    .rhs_valid       (rhs_valid),
    .result_ready    (result_ready),
    .cfg_write       (cfg_write),
    .cfg_predicate   (cfg_predicate),
    .lhs_ready       (lhs_ready),
    .rhs_ready       (rhs_ready),
    .result          (result),
    .result_valid    (result_valid),
    .predicate_error (predicate_error)
  );

  bind fp_cmp_top fp_cmp_props u_props (
    .clk             (clk),
    .reset           (reset),
    .lhs_valid       (lhs_valid),
    .rhs_valid       (rhs_valid),
    .lhs_ready       (lhs_ready),
    .rhs_ready       (rhs_ready),
    .result          (result),
    .result_valid    (result_valid),
    .result_ready    (result_ready),
    .predicate_error (predicate_error)
  );

  function automatic logic is_nan(input logic [31:0] v);
    return v[30:23] == 8'hff && v[22:0] != 23'd0;
  endfunction

  function automatic logic is_zero(input logic [31:0] v);
    return v[30:0] == 31'd0;
  endfunction

  // Sign and magnitude order with both zeros equal
  function automatic logic fp_less(input logic [31:0] a, input logic [31:0] b);
    logic less;
    if (is_zero(a) && is_zero(b)) begin
      less = 1'b0;
    end else if (a[31] != b[31]) begin
      less = a[31];
    end else if (a[31]) begin
      less = a[30:0] > b[30:0];
    end else begin
      less = a[30:0] < b[30:0];
    end
    return less;
  endfunction

  function automatic logic expected_result(input logic [31:0] a, input logic [31:0] b,
                                           input logic [3:0] pred);
    logic uno;
    logic lt;
    logic gt;
    logic eq;
    logic r;
    uno = is_nan(a) || is_nan(b);
    lt  = fp_less(a, b);
    gt  = fp_less(b, a);
    eq  = (is_zero(a) && is_zero(b)) || a == b;
    case (pred)
      cmp_pkg::OEQ: r = !uno && eq;
      cmp_pkg::OGT: r = !uno && gt;
      cmp_pkg::OGE: r = !uno && (gt || eq);
      cmp_pkg::OLT: r = !uno && lt;
      cmp_pkg::OLE: r = !uno && (lt || eq);
      cmp_pkg::ONE: r = !uno && !eq;
      cmp_pkg::ORD: r = !uno;
      cmp_pkg::UEQ: r = uno || eq;
      cmp_pkg::UGT: r = uno || gt;
      cmp_pkg::UGE: r = uno || gt || eq;
      cmp_pkg::ULT: r = uno || lt;
      cmp_pkg::ULE: r = uno || lt || eq;
      cmp_pkg::UNE: r = uno || !eq;
      cmp_pkg::UNO: r = uno;
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s failed: %s", test_name, what);
  endtask

  // One clock of stimulus and bookkeeping
  task automatic cycle();
    bit expected;
    int accepted_window;
    @(negedge clk);
    lhs_valid     = have_pair;
    rhs_valid     = have_pair;
    lhs           = pair_lhs;
    rhs           = pair_rhs;
    cfg_write     = cfg_pending;
    cfg_predicate = cfg_code;
    case (ready_mode)
      READY_LOW:    result_ready = 1'b0;
      READY_RANDOM: result_ready = ($urandom % 3) != 0;
      default:      result_ready = 1'b1;
    endcase
    #1;
    check_value("predicate_error", 32'(model_error), 32'(predicate_error));
    if (lhs_ready && !have_pair) begin
      report_failure("operand ready raised with no pair offered");
    end else if (lhs_ready) begin
      exp_q.push_back(expected_result(pair_lhs, pair_rhs, model_pred));
      win_q.push_back(window);
      have_pair = 1'b0;
    end
    if (result_valid && result_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("result delivered with no pair outstanding");
      end else begin
        expected        = exp_q.pop_front();
        accepted_window = win_q.pop_front();
        check_value("result", 32'(expected), 32'(result));
        if (check_latency) begin
          check_value("latency", 32'd2, 32'(window - accepted_window));
        end
      end
    end
    // The write lands at the coming edge and only codes 0 to 13 take effect
    if (cfg_pending) begin
      if (cfg_code <= 4'd13) begin
        model_pred  = cfg_code;
        model_error = 1'b0;
      end else begin
        model_error = 1'b1;
      end
      cfg_pending = 1'b0;
    end
    window++;
  endtask

  task automatic write_predicate(input logic [3:0] code);
    cfg_pending = 1'b1;
    cfg_code    = code;
    cycle();
  endtask

  task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
    int waited = 0;
    have_pair = 1'b1;
    pair_lhs  = a;
    pair_rhs  = b;
    while (have_pair && waited < WAIT_LIMIT) begin
      cycle();
      waited++;
    end
    if (have_pair) begin
      report_failure("operand pair was never accepted");
      have_pair = 1'b0;
    end
  endtask

  task automatic drain_results();
    int waited = 0;
    while ((exp_q.size() != 0 || have_pair) && waited < WAIT_LIMIT) begin
      cycle();
      waited++;
    end
    if (exp_q.size() != 0 || have_pair) begin
      report_failure($sformatf("%0d results never arrived", exp_q.size()));
      exp_q.delete();
      win_q.delete();
      have_pair = 1'b0;
    end
    // Idle cycles catch repeated results
    repeat (4) cycle();
  endtask

  task automatic random_operand(output logic [31:0] v);
    case ($urandom % 8)
      0: v = (($urandom % 2) != 0) ? 32'h8000_0000 : 32'h0000_0000;
      1: v = (($urandom % 2) != 0) ? FP_MINF : FP_PINF;
      2: v = FP_QNAN | ($urandom & 32'h803f_ffff);
      default: v = $urandom;
    endcase
  endtask

  task automatic load_random_pair();
    logic [31:0] a;
    logic [31:0] b;
    random_operand(a);
    random_operand(b);
    have_pair = 1'b1;
    pair_lhs  = a;
    pair_rhs  = (($urandom % 4) == 0) ? a : b;
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
    ready_mode        = READY_HIGH;
  endtask

  task automatic end_test();
    $display("test %s done, %0d errors", test_name, errors - test_start_errors);
  endtask

  task automatic test_reset_state();
    begin_test("reset_state");
    cycle();
    check_value("result_valid", 32'd0, 32'(result_valid));
    check_value("lhs_ready", 32'd0, 32'(lhs_ready));
    check_value("rhs_ready", 32'd0, 32'(rhs_ready));
    check_value("predicate_error", 32'd0, 32'(predicate_error));
    // Only OEQ gives this pattern over these four pairs
    send_pair(FP_ONE, FP_ONE);
    send_pair(FP_ONE, FP_TWO);
    send_pair(FP_TWO, FP_ONE);
    send_pair(FP_QNAN, FP_ONE);
    drain_results();
    end_test();
  endtask

  task automatic test_all_predicates();
    begin_test("all_predicates");
    for (int p = 0; p < 14; p++) begin
      write_predicate(4'(p));
      for (int i = 0; i < NUM_DIRECTED; i++) begin
        send_pair(DIRECTED[i][63:32], DIRECTED[i][31:0]);
      end
      drain_results();
    end
    end_test();
  endtask

  task automatic test_random_pairs();
    int cycles;
    int sent;
    begin_test("random_pairs");
    check_latency = 1'b1;
    for (int burst = 0; burst < 8; burst++) begin
      write_predicate(4'($urandom % 14));
      sent   = 0;
      cycles = 0;
      while ((sent < 24 || have_pair) && cycles < WAIT_LIMIT) begin
        if (!have_pair && sent < 24) begin
          load_random_pair();
          sent++;
        end
        cycle();
        cycles++;
      end
      // One pair per cycle with no stall
      check_value("cycles per burst", 32'd24, 32'(cycles));
      drain_results();
    end
    check_latency = 1'b0;
    end_test();
  endtask

  task automatic test_back_pressure();
    int cycles = 0;
    int sent = 0;
    begin_test("back_pressure");
    write_predicate(cmp_pkg::ULE);
    ready_mode = READY_RANDOM;
    while ((sent < 60 || have_pair) && cycles < 5 * WAIT_LIMIT) begin
      if (!have_pair && sent < 60 && ($urandom % 4) != 0) begin
        load_random_pair();
        sent++;
      end
      cycle();
      cycles++;
    end
    if (have_pair || sent < 60) begin
      report_failure("operand stream stalled under back-pressure");
    end
    ready_mode = READY_HIGH;
    drain_results();
    end_test();
  endtask

  task automatic test_undefined_code();
    begin_test("undefined_code");
    write_predicate(cmp_pkg::OLT);
    write_predicate(4'd14);
    cycle();
    check_value("flag after code 14", 32'd1, 32'(predicate_error));
    send_pair(FP_ONE, FP_TWO);
    send_pair(FP_TWO, FP_ONE);
    write_predicate(4'd15);
    drain_results();
    write_predicate(cmp_pkg::OGE);
    cycle();
    check_value("flag after defined write", 32'd0, 32'(predicate_error));
    send_pair(FP_ONE, FP_TWO);
    drain_results();
    end_test();
  endtask

  task automatic test_change_in_flight();
    begin_test("change_in_flight");
    write_predicate(cmp_pkg::OLT);
    ready_mode = READY_LOW;
    // Two pairs fill both stages
    send_pair(FP_ONE, FP_TWO);
    send_pair(FP_ONE, FP_TWO);
    have_pair = 1'b1;
    pair_lhs  = FP_ONE;
    pair_rhs  = FP_TWO;
    repeat (3) cycle();
    check_value("third pair held off", 32'd1, 32'(have_pair));
    write_predicate(cmp_pkg::OGE);
    ready_mode = READY_HIGH;
    drain_results();
    end_test();
  endtask

  initial begin
    void'($urandom(32'hadf0));
    reset         = 1'b1;
    lhs           = '0;
    lhs_valid     = 1'b0;
    rhs           = '0;
    rhs_valid     = 1'b0;
    result_ready  = 1'b0;
    cfg_write     = 1'b0;
    cfg_predicate = '0;
    have_pair     = 1'b0;
    pair_lhs      = '0;
    pair_rhs      = '0;
    cfg_pending   = 1'b0;
    cfg_code      = '0;
    ready_mode    = READY_HIGH;
    check_latency = 1'b0;
    model_pred    = cmp_pkg::OEQ;
    model_error   = 1'b0;
    window        = 0;
    checks        = 0;
    errors        = 0;
    test_name     = "setup";
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_all_predicates();
    test_random_pairs();
    test_back_pressure();
    test_undefined_code();
    test_change_in_flight();

    errors += UUT.u_props.failures;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             UUT.u_props.failures);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 4;

  // Free running, 8 unit period
  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule
